// File: source/rename_pkg.sv
`default_nettype none

package rename_pkg;

    // architectural and physical register files
    localparam int arch_reg_count = 8;
    localparam int phys_reg_count = 16;

    // result broadcast lanes per cycle
    localparam int cdb_width = 2;

    // reorder buffer depth
    localparam int rob_size = 16;

    typedef logic [$clog2(arch_reg_count)-1:0] arch_idx_t;

    typedef logic [$clog2(phys_reg_count)-1:0] phys_tag_t;

    typedef logic [$clog2(rob_size)-1:0] rob_idx_t;

    // head can reach phys_reg_count, so one extra bit
    typedef logic [$clog2(phys_reg_count + 1)-1:0] fl_ptr_t;

    // whole map, indexed by architectural register
    typedef phys_tag_t [arch_reg_count-1:0] map_tags_t;

    typedef logic [arch_reg_count-1:0] map_ready_t;

endpackage

`default_nettype wire

// File: source/branch_pkg.sv
`default_nettype none

package branch_pkg;

    // number of checkpoints, one per unresolved branch
    localparam int branch_depth = 4;

    // one-hot branch id, or a mask of several ids
    typedef logic [branch_depth-1:0] branch_id_t;

    // what the execute stage reports for a resolved branch
    typedef enum logic [1:0] {
        br_none   = 2'd0,
        br_clear  = 2'd1,
        br_squash = 2'd2
    } br_task_t;

endpackage

`default_nettype wire

// File: source/free_slot_select.sv
`timescale 1ns/1ps
`default_nettype none

module free_slot_select (
    input  branch_pkg::branch_id_t free,
    output branch_pkg::branch_id_t grant,
    output logic                   none_free
);

    // bits already claimed by a lower slot
    logic [branch_pkg::branch_depth:0] taken;

    always_comb begin
        taken    = '0;
        grant    = '0;
        for (int i = 0; i < branch_pkg::branch_depth; i++) begin
            // lowest set bit wins
            grant[i]     = free[i] & ~taken[i];
            taken[i + 1] = taken[i] | free[i];
        end
    end

    assign none_free = ~taken[branch_pkg::branch_depth];

endmodule

`default_nettype wire

// File: source/map_table.sv
`timescale 1ns/1ps
`default_nettype none

module map_table (
    input  logic                                                  clock,
    input  logic                                                  reset,

    input  logic                                                  rename_valid,
    input  rename_pkg::arch_idx_t                                 rename_arch,
    input  rename_pkg::phys_tag_t                                 rename_phys,

    input  logic                  [rename_pkg::cdb_width-1:0]     cdb_valid,
    input  rename_pkg::arch_idx_t [rename_pkg::cdb_width-1:0]     cdb_arch,
    input  rename_pkg::phys_tag_t [rename_pkg::cdb_width-1:0]     cdb_phys,

    input  logic                                                  restore_valid,
    input  rename_pkg::map_tags_t                                 restore_tags,
    input  rename_pkg::map_ready_t                                restore_ready,

    output rename_pkg::map_tags_t                                 map_tags,
    output rename_pkg::map_ready_t                                map_ready,

    input  rename_pkg::arch_idx_t                                 lookup_arch,
    output rename_pkg::phys_tag_t                                 lookup_phys,
    output logic                                                  lookup_ready
);

    rename_pkg::map_tags_t  next_tags;
    rename_pkg::map_ready_t next_ready;

    always_comb begin
        // a restore replaces the whole map, a rename touches one entry
        if (restore_valid) begin
            next_tags  = restore_tags;
            next_ready = restore_ready;
        end else begin
            next_tags  = map_tags;
            next_ready = map_ready;
            if (rename_valid) begin
                next_tags[rename_arch]  = rename_phys;
                next_ready[rename_arch] = 1'b0;
            end
        end

        // wakeup on the map that is about to be stored
        for (int l = 0; l < rename_pkg::cdb_width; l++) begin
            if (cdb_valid[l] && next_tags[cdb_arch[l]] == cdb_phys[l]) begin
                next_ready[cdb_arch[l]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map, everything ready
            for (int i = 0; i < rename_pkg::arch_reg_count; i++) begin
                map_tags[i] <= rename_pkg::phys_tag_t'(i);
            end
            map_ready <= '1;
        end else begin
            map_tags  <= next_tags;
            map_ready <= next_ready;
        end
    end

    // read straight from the registered map
    assign lookup_phys  = map_tags[lookup_arch];
    assign lookup_ready = map_ready[lookup_arch];

endmodule

`default_nettype wire

// File: source/branch_stack.sv
`timescale 1ns/1ps
`default_nettype none

module branch_stack (
    input  logic                                                  clock,
    input  logic                                                  reset,

    input  logic                                                  branch_dispatch,

    input  rename_pkg::map_tags_t                                 map_tags,
    input  rename_pkg::map_ready_t                                map_ready,
    input  rename_pkg::fl_ptr_t                                   fl_head,
    input  rename_pkg::rob_idx_t                                  rob_tail,

    input  logic                  [rename_pkg::cdb_width-1:0]     cdb_valid,
    input  rename_pkg::arch_idx_t [rename_pkg::cdb_width-1:0]     cdb_arch,
    input  rename_pkg::phys_tag_t [rename_pkg::cdb_width-1:0]     cdb_phys,

    input  branch_pkg::br_task_t                                  resolve_task,
    input  branch_pkg::branch_id_t                                resolve_id,

    output branch_pkg::branch_id_t                                assigned_id,
    output logic                                                  stack_full,

    output logic                                                  recover_valid,
    output rename_pkg::map_tags_t                                 recover_tags,
    output rename_pkg::map_ready_t                                recover_ready,
    output rename_pkg::fl_ptr_t                                   recover_fl_head,
    output rename_pkg::rob_idx_t                                  recover_rob_tail
);

    localparam int depth = branch_pkg::branch_depth;

    // control state
    logic                   [depth-1:0] entry_valid;
    branch_pkg::branch_id_t [depth-1:0] entry_id;
    branch_pkg::branch_id_t [depth-1:0] entry_mask;

    // checkpoint payload
    rename_pkg::map_tags_t  [depth-1:0] entry_tags;
    rename_pkg::map_ready_t [depth-1:0] entry_ready;
    rename_pkg::fl_ptr_t    [depth-1:0] entry_fl;
    rename_pkg::rob_idx_t   [depth-1:0] entry_rob;

    logic                   [depth-1:0] next_valid;
    branch_pkg::branch_id_t [depth-1:0] next_id;
    branch_pkg::branch_id_t [depth-1:0] next_mask;
    rename_pkg::map_tags_t  [depth-1:0] next_tags;
    rename_pkg::map_ready_t [depth-1:0] next_ready;
    rename_pkg::fl_ptr_t    [depth-1:0] next_fl;
    rename_pkg::rob_idx_t   [depth-1:0] next_rob;

    branch_pkg::branch_id_t free_slots;
    branch_pkg::branch_id_t slot_grant;
    branch_pkg::branch_id_t new_mask;
    logic                   none_free;
    logic                   squash;
    logic                   clear;
    logic                   write_en;

    assign free_slots = ~entry_valid;

    free_slot_select u_free_slot_select (
        .free      (free_slots),
        .grant     (slot_grant),
        .none_free (none_free)
    );

    assign stack_full = none_free;
    assign squash     = resolve_task == branch_pkg::br_squash;
    assign clear      = resolve_task == branch_pkg::br_clear;

    // a flushed front end ignores the id, so it is shown even on squash
    assign assigned_id = (branch_dispatch && !none_free) ? slot_grant : '0;
    assign write_en    = branch_dispatch && !none_free && !squash;

    always_comb begin
        next_valid = entry_valid;
        next_id    = entry_id;
        next_mask  = entry_mask;
        next_tags  = entry_tags;
        next_ready = entry_ready;
        next_fl    = entry_fl;
        next_rob   = entry_rob;

        recover_valid    = 1'b0;
        recover_tags     = '0;
        recover_ready    = '0;
        recover_fl_head  = '0;
        recover_rob_tail = '0;

        for (int i = 0; i < depth; i++) begin
            if (squash && entry_valid[i]) begin
                if (entry_id[i] == resolve_id) begin
                    recover_valid    = 1'b1;
                    recover_tags     = entry_tags[i];
                    recover_ready    = entry_ready[i];
                    recover_fl_head  = entry_fl[i];
                    recover_rob_tail = entry_rob[i];
                end
                // the branch itself and everything younger goes
                if (((entry_mask[i] | entry_id[i]) & resolve_id) != '0) begin
                    next_valid[i] = 1'b0;
                    next_id[i]    = '0;
                    next_mask[i]  = '0;
                end
            end
            if (clear && entry_valid[i]) begin
                if (entry_id[i] == resolve_id) begin
                    next_valid[i] = 1'b0;
                    next_id[i]    = '0;
                    next_mask[i]  = '0;
                end else begin
                    next_mask[i] = entry_mask[i] & ~resolve_id;
                end
            end
        end

        // new branch depends on every id still live after this cycle
        new_mask = '0;
        for (int j = 0; j < depth; j++) begin
            if (next_valid[j]) begin
                new_mask = new_mask | next_id[j];
            end
        end

        if (write_en) begin
            for (int k = 0; k < depth; k++) begin
                if (slot_grant[k]) begin
                    next_valid[k] = 1'b1;
                    next_id[k]    = slot_grant;
                    next_mask[k]  = new_mask;
                    next_tags[k]  = map_tags;
                    next_ready[k] = map_ready;
                    next_fl[k]    = fl_head;
                    next_rob[k]   = rob_tail;
                end
            end
        end

        // wakeup reaches the checkpoint written this cycle too
        for (int l = 0; l < rename_pkg::cdb_width; l++) begin
            for (int j = 0; j < depth; j++) begin
                if (cdb_valid[l] && next_valid[j]
                        && next_tags[j][cdb_arch[l]] == cdb_phys[l]) begin
                    next_ready[j][cdb_arch[l]] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            entry_id    <= '0;
            entry_mask  <= '0;
        end else begin
            entry_valid <= next_valid;
            entry_id    <= next_id;
            entry_mask  <= next_mask;
        end
    end

    always_ff @(posedge clock) begin
        entry_tags  <= next_tags;
        entry_ready <= next_ready;
        entry_fl    <= next_fl;
        entry_rob   <= next_rob;
    end

endmodule

`default_nettype wire

// File: source/branch_recovery.sv
`timescale 1ns/1ps
`default_nettype none

module branch_recovery (
    input  logic                                                  clock,
    input  logic                                                  reset,

    input  logic                                                  dispatch_valid,
    input  logic                                                  dispatch_is_branch,
    input  rename_pkg::arch_idx_t                                 dispatch_dest_arch,
    input  rename_pkg::phys_tag_t                                 dispatch_dest_phys,
    input  logic                                                  dispatch_has_dest,

    input  rename_pkg::fl_ptr_t                                   fl_head,
    input  rename_pkg::rob_idx_t                                  rob_tail,

    input  logic                  [rename_pkg::cdb_width-1:0]     cdb_valid,
    input  rename_pkg::arch_idx_t [rename_pkg::cdb_width-1:0]     cdb_arch,
    input  rename_pkg::phys_tag_t [rename_pkg::cdb_width-1:0]     cdb_phys,

    input  branch_pkg::br_task_t                                  resolve_task,
    input  branch_pkg::branch_id_t                                resolve_id,

    input  rename_pkg::arch_idx_t                                 lookup_arch,
    output rename_pkg::phys_tag_t                                 lookup_phys,
    output logic                                                  lookup_ready,

    output branch_pkg::branch_id_t                                assigned_id,
    output logic                                                  stack_full,
    output logic                                                  recover_valid,
    output rename_pkg::fl_ptr_t                                   recover_fl_head,
    output rename_pkg::rob_idx_t                                  recover_rob_tail
);

    logic                   branch_dispatch;
    logic                   rename_valid;
    rename_pkg::map_tags_t  map_tags;
    rename_pkg::map_ready_t map_ready;
    rename_pkg::map_tags_t  recover_tags;
    rename_pkg::map_ready_t recover_ready;

    assign branch_dispatch = dispatch_valid && dispatch_is_branch;

    // only non-branch writers rename, and never while the front end is flushed
    assign rename_valid = dispatch_valid && !dispatch_is_branch && dispatch_has_dest
                          && (resolve_task != branch_pkg::br_squash);

    branch_stack u_branch_stack (
        .clock            (clock),
        .reset            (reset),
        .branch_dispatch  (branch_dispatch),
        .map_tags         (map_tags),
        .map_ready        (map_ready),
        .fl_head          (fl_head),
        .rob_tail         (rob_tail),
        .cdb_valid        (cdb_valid),
        .cdb_arch         (cdb_arch),
        .cdb_phys         (cdb_phys),
        .resolve_task     (resolve_task),
        .resolve_id       (resolve_id),
        .assigned_id      (assigned_id),
        .stack_full       (stack_full),
        .recover_valid    (recover_valid),
        .recover_tags     (recover_tags),
        .recover_ready    (recover_ready),
        .recover_fl_head  (recover_fl_head),
        .recover_rob_tail (recover_rob_tail)
    );

    map_table u_map_table (
        .clock         (clock),
        .reset         (reset),
        .rename_valid  (rename_valid),
        .rename_arch   (dispatch_dest_arch),
        .rename_phys   (dispatch_dest_phys),
        .cdb_valid     (cdb_valid),
        .cdb_arch      (cdb_arch),
        .cdb_phys      (cdb_phys),
        .restore_valid (recover_valid),
        .restore_tags  (recover_tags),
        .restore_ready (recover_ready),
        .map_tags      (map_tags),
        .map_ready     (map_ready),
        .lookup_arch   (lookup_arch),
        .lookup_phys   (lookup_phys),
        .lookup_ready  (lookup_ready)
    );

endmodule

`default_nettype wire

// File: testbench/branch_recovery_checker.sv
`timescale 1ns/1ps
`default_nettype none

module branch_recovery_checker (
    input logic                   clock,
    input logic                   reset,
    input branch_pkg::branch_id_t assigned_id,
    input logic                   stack_full,
    input logic                   recover_valid,
    input branch_pkg::br_task_t   resolve_task
);

    // at most one slot handed out per cycle
    assert property (@(posedge clock) disable iff (reset) $onehot0(assigned_id))
        else $error("assigned_id has more than one bit set");

    assert property (@(posedge clock) disable iff (reset) stack_full |-> assigned_id == '0)
        else $error("branch id handed out while the stack is full");

    // only a squash restores a checkpoint
    assert property (@(posedge clock) disable iff (reset)
        recover_valid |-> resolve_task == branch_pkg::br_squash)
        else $error("recovery without a squash request");

    assert property (@(posedge clock) reset |-> !recover_valid)
        else $error("recovery during reset");

    assert property (@(posedge clock) reset |=> !recover_valid)
        else $error("recovery in the first cycle after reset");

endmodule

`default_nettype wire

// File: testbench/branch_recovery_tb.sv
`timescale 1ns/1ps
`default_nettype none

module branch_recovery_tb;

    localparam int num_cycles    = 1500;
    // reset plus some slack on top of the random run
    localparam int timeout_limit = num_cycles + 100;

    logic clock, reset, lookup_ready, stack_full, recover_valid;
    logic dispatch_valid, dispatch_is_branch, dispatch_has_dest;
    rename_pkg::arch_idx_t dispatch_dest_arch, lookup_arch;
    rename_pkg::phys_tag_t dispatch_dest_phys, lookup_phys;
    rename_pkg::fl_ptr_t fl_head, recover_fl_head;
    rename_pkg::rob_idx_t rob_tail, recover_rob_tail;
    logic [rename_pkg::cdb_width-1:0] cdb_valid;
    rename_pkg::arch_idx_t [rename_pkg::cdb_width-1:0] cdb_arch;
    rename_pkg::phys_tag_t [rename_pkg::cdb_width-1:0] cdb_phys;
    branch_pkg::br_task_t resolve_task;
    branch_pkg::branch_id_t resolve_id, assigned_id;

    logic [31:0] lfsr_state;
    int cycle_count;
    // reference model of the live map and one checkpoint per slot
    rename_pkg::map_tags_t model_tags;
    rename_pkg::map_ready_t model_ready;
    branch_pkg::branch_id_t cp_valid;
    branch_pkg::branch_id_t cp_mask [branch_pkg::branch_depth];
    rename_pkg::map_tags_t cp_tags [branch_pkg::branch_depth];
    rename_pkg::map_ready_t cp_ready [branch_pkg::branch_depth];
    rename_pkg::fl_ptr_t cp_fl [branch_pkg::branch_depth];
    rename_pkg::rob_idx_t cp_rob [branch_pkg::branch_depth];

    branch_recovery DUT (.*);

    bind branch_recovery branch_recovery_checker u_checker (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int b = 0; b < count; b++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("mismatch %s expected %0h actual %0h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // sweep the read port over every architectural register
    task automatic check_map(input string name);
        for (int a = 0; a < rename_pkg::arch_reg_count; a++) begin
            lookup_arch = rename_pkg::arch_idx_t'(a);
            #1;
            check_value(name, 32'(model_tags[a]), 32'(lookup_phys));
            check_value({name, " ready"}, 32'(model_ready[a]), 32'(lookup_ready));
        end
    endtask

    task automatic drive_random(input int cycle);
        logic [3:0] sel;
        logic [1:0] idx;
        dispatch_valid     = rand_bits(2) != 0;
        dispatch_is_branch = rand_bits(1) != 0;
        dispatch_has_dest  = rand_bits(2) != 0;
        dispatch_dest_arch = rename_pkg::arch_idx_t'(rand_bits(3));
        dispatch_dest_phys = rename_pkg::phys_tag_t'(rand_bits(4));
        fl_head            = rename_pkg::fl_ptr_t'(rand_bits(5));
        rob_tail           = rename_pkg::rob_idx_t'(rand_bits(4));
        for (int l = 0; l < rename_pkg::cdb_width; l++) begin
            cdb_valid[l] = rand_bits(1) != 0;
            cdb_arch[l]  = rename_pkg::arch_idx_t'(rand_bits(3));
            idx          = 2'(rand_bits(2));
            // mostly tags held somewhere, so wakeups actually hit
            if (idx[1])
                cdb_phys[l] = model_tags[cdb_arch[l]];
            else if (idx[0])
                cdb_phys[l] = cp_tags[2'(rand_bits(2))][cdb_arch[l]];
            else
                cdb_phys[l] = rename_pkg::phys_tag_t'(rand_bits(4));
        end
        sel          = 4'(rand_bits(4));
        idx          = 2'(rand_bits(2));
        resolve_task = branch_pkg::br_none;
        resolve_id   = '0;
        // every third block of 100 cycles has no resolves, so the stack fills up
        if ((cycle / 100) % 3 != 2 && sel >= 4'd10) begin
            resolve_task = (sel >= 4'd13) ? branch_pkg::br_squash : branch_pkg::br_clear;
            if (cp_valid != '0 && rand_bits(3) != 0) begin
                for (int k = 0; k < branch_pkg::branch_depth; k++)
                    if (!cp_valid[idx]) idx = idx + 2'd1;
                resolve_id = branch_pkg::branch_id_t'(1 << idx);
            end else begin
                // an id that no live branch holds
                resolve_id = cp_valid[idx] ? '0 : branch_pkg::branch_id_t'(1 << idx);
            end
        end
    endtask

    // compare the strobe outputs, then step the model by one clock
    task automatic check_and_update();
        rename_pkg::map_tags_t  old_tags;
        rename_pkg::map_ready_t old_ready;
        branch_pkg::branch_id_t new_id;
        branch_pkg::branch_id_t own_id;
        logic                   squash;
        int                     low;
        int                     hit;
        squash = resolve_task == branch_pkg::br_squash;
        low    = 0;
        while (low < branch_pkg::branch_depth - 1 && cp_valid[low])
            low++;
        new_id = (dispatch_valid && dispatch_is_branch && cp_valid != '1)
                 ? branch_pkg::branch_id_t'(1 << low) : '0;
        hit = -1;
        for (int i = 0; i < branch_pkg::branch_depth; i++)
            if (squash && cp_valid[i] && branch_pkg::branch_id_t'(1 << i) == resolve_id)
                hit = i;
        check_value("id_alloc", 32'(new_id), 32'(assigned_id));
        check_value("stack_full", 32'(cp_valid == '1), 32'(stack_full));
        check_value("squash_recover", 32'(hit >= 0), 32'(recover_valid));
        if (hit >= 0) begin
            check_value("squash_fl_head", 32'(cp_fl[hit]), 32'(recover_fl_head));
            check_value("squash_rob_tail", 32'(cp_rob[hit]), 32'(recover_rob_tail));
        end

        old_tags  = model_tags;
        old_ready = model_ready;
        if (hit >= 0) begin
            model_tags  = cp_tags[hit];
            model_ready = cp_ready[hit];
        end else if (dispatch_valid && !dispatch_is_branch && dispatch_has_dest && !squash) begin
            model_tags[dispatch_dest_arch]  = dispatch_dest_phys;
            model_ready[dispatch_dest_arch] = 1'b0;
        end
        for (int i = 0; i < branch_pkg::branch_depth; i++) begin
            own_id = branch_pkg::branch_id_t'(1 << i);
            // squash takes the branch and everything that depends on it
            if (squash && ((cp_mask[i] | own_id) & resolve_id) != '0)
                cp_valid[i] = 1'b0;
            if (resolve_task == branch_pkg::br_clear && own_id == resolve_id)
                cp_valid[i] = 1'b0;
            else if (resolve_task == branch_pkg::br_clear)
                cp_mask[i] = cp_mask[i] & ~resolve_id;
        end
        // new branch depends on whatever survives this cycle
        if (new_id != '0 && !squash) begin
            cp_mask[low]  = cp_valid;
            cp_valid[low] = 1'b1;
            cp_tags[low]  = old_tags;
            cp_ready[low] = old_ready;
            cp_fl[low]    = fl_head;
            cp_rob[low]   = rob_tail;
        end
        for (int l = 0; l < rename_pkg::cdb_width; l++) begin
            if (cdb_valid[l] && model_tags[cdb_arch[l]] == cdb_phys[l])
                model_ready[cdb_arch[l]] = 1'b1;
            for (int i = 0; i < branch_pkg::branch_depth; i++)
                if (cdb_valid[l] && cp_valid[i] && cp_tags[i][cdb_arch[l]] == cdb_phys[l])
                    cp_ready[i][cdb_arch[l]] = 1'b1;
        end
    endtask

    initial begin
        lfsr_state         = 32'h8056;
        reset              = 1'b1;
        dispatch_valid     = 1'b0;
        dispatch_is_branch = 1'b0;
        dispatch_has_dest  = 1'b0;
        dispatch_dest_arch = '0;
        dispatch_dest_phys = '0;
        fl_head            = '0;
        rob_tail           = '0;
        cdb_valid          = '0;
        cdb_arch           = '0;
        cdb_phys           = '0;
        resolve_task       = branch_pkg::br_none;
        resolve_id         = '0;
        lookup_arch        = '0;

        // identity map, all ready, empty stack
        for (int i = 0; i < rename_pkg::arch_reg_count; i++)
            model_tags[i] = rename_pkg::phys_tag_t'(i);
        model_ready = '1;
        cp_valid    = '0;
        for (int i = 0; i < branch_pkg::branch_depth; i++) begin
            cp_mask[i]  = '0;
            cp_tags[i]  = '0;
            cp_ready[i] = '0;
        end

        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // squash request on an empty stack, nothing may be recovered
        resolve_task = branch_pkg::br_squash;
        resolve_id   = branch_pkg::branch_id_t'(1);
        check_map("reset_state");
        check_value("reset_state stack_full", 32'd0, 32'(stack_full));
        check_value("reset_state assigned_id", 32'd0, 32'(assigned_id));
        check_value("reset_state recover_valid", 32'd0, 32'(recover_valid));

        for (int c = 0; c < num_cycles; c++) begin
            @(negedge clock);
            drive_random(c);
            check_map("rename_wakeup");
            check_and_update();
        end
        $display("** PASS **");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("error: simulation still running after %0d cycles", timeout_limit);
        $display("** FAIL **");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: branch_recovery.f
source/rename_pkg.sv
source/branch_pkg.sv
source/free_slot_select.sv
source/map_table.sv
source/branch_stack.sv
source/branch_recovery.sv
testbench/branch_recovery_checker.sv
testbench/branch_recovery_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run with Verilator; an aborted build or run is logged as a failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module branch_recovery_tb -f branch_recovery.f \
    -o branch_recovery_sim > sim.log 2>&1 \
    && ./obj_dir/branch_recovery_sim >> sim.log 2>&1 \
    || echo "** FAIL **" >> sim.log

cat sim.log
grep -qF "** FAIL **" sim.log && exit 1 || exit 0
